// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_uart_fifo
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: byte_fifo.sv
`include "uart_consts.svh"

module byte_fifo
    import uart_pkg::*, fifo_bus_pkg::*;
(
    fifo_bus_if.slave bus,
    input logic       clk,
    input logic       rst_n
);

    localparam fifo_count_t DEPTH = fifo_count_t'(`FIFO_DEPTH);

    byte_t       mem [`FIFO_DEPTH];
    fifo_ptr_t   rd_ptr;
    fifo_ptr_t   wr_ptr;
    fifo_count_t count;
    logic        req;                           // New transfer this cycle
    logic        do_wr;
    logic        do_rd;

    assign req   = bus.cyc && bus.stb && !bus.ack;
    assign do_wr = req && bus.we && !bus.full;  // Full write is acked, not stored
    assign do_rd = req && !bus.we && !bus.empty;

    assign bus.empty = (count == '0);
    assign bus.full  = (count == DEPTH);
    assign bus.head  = bus.empty ? '0 : mem[rd_ptr];

    //////////////////////////////
    // Pointers and status

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            bus.ack  <= 1'b0;
            bus.last <= '0;
        end
        else
        begin
            bus.ack <= req;                     // Single cycle, one after stb
            if (do_wr)
            begin
                wr_ptr   <= wr_ptr + 1'b1;
                bus.last <= bus.dat_w;          // Kept after reads
            end
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;        // Pop
            if (do_wr)
                count <= count + 1'b1;
            else if (do_rd)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= bus.dat_w;
        if (req && !bus.we)
            bus.dat_r <= bus.head;              // 0 on an empty read
    end

    a_ack_with_stb: assert property (@(posedge clk) disable iff (!rst_n)
        bus.ack |-> bus.stb);

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= DEPTH);

endmodule

// File: fifo_bus_if.sv
interface fifo_bus_if
    import uart_pkg::*;
();

    logic  cyc;                                 // Cycle in progress
    logic  stb;                                 // Transfer strobe
    logic  we;                                  // 1 write, 0 read
    byte_t dat_w;                               // Write data
    byte_t dat_r;                               // Read data, valid with ack
    logic  ack;                                 // One-cycle acknowledge

    logic  empty;                               // Status, no entries
    logic  full;                                // Status, all entries used
    byte_t last;                                // Most recently written byte
    byte_t head;                                // Oldest byte, 0 when empty

    modport master (
        output cyc, stb, we, dat_w,
        input  dat_r, ack, empty, full
    );

    modport slave (
        input  cyc, stb, we, dat_w,
        output dat_r, ack, empty, full, last, head
    );

endinterface

// File: fifo_bus_pkg.sv
`include "uart_consts.svh"

package fifo_bus_pkg;

    // Index into the entry array
    typedef logic [$clog2(`FIFO_DEPTH)-1:0] fifo_ptr_t;

    // Occupancy, 0 up to and including FIFO_DEPTH
    typedef logic [$clog2(`FIFO_DEPTH+1)-1:0] fifo_count_t;

    // Which direction the unit is working in
    typedef enum logic {
        MODE_RECEIVE  = 1'b0,                   // Writes into the store
        MODE_TRANSMIT = 1'b1                    // Reads out of the store
    } link_mode_t;

endpackage

// File: files.f
+incdir+.
uart_pkg.sv
fifo_bus_pkg.sv
fifo_bus_if.sv
uart_rx.sv
uart_tx.sv
byte_fifo.sv
link_ctrl.sv
uart_fifo_top.sv
tb_uart_fifo.sv

// File: link_ctrl.sv
module link_ctrl
    import uart_pkg::*, fifo_bus_pkg::*;
(
    fifo_bus_if.master bus,
    input  logic       clk,
    input  logic       rst_n,
    input  link_mode_t mode,
    input  byte_t      rx_data,
    input  logic       rx_valid,
    input  logic       load,
    input  byte_t      load_data,
    input  logic       send,
    input  logic       tx_busy,
    output logic       tx_start,
    output byte_t      tx_data
);

    logic  load_q;
    logic  send_q;
    logic  load_edge;
    logic  send_edge;
    logic  rx_mode;
    logic  rd_busy;                             // Read on the bus
    logic  send_ok;                             // Send edge accepted
    logic  rx_pend;
    logic  ld_pend;
    logic  send_pend;
    byte_t rx_byte;                             // Captured received byte
    byte_t ld_byte;                             // Captured load byte

    assign rx_mode   = (mode == MODE_RECEIVE);
    assign load_edge = load && !load_q;
    assign send_edge = send && !send_q;
    assign rd_busy   = bus.cyc && !bus.we;
    // One read in flight at a time, and never into a busy transmitter
    assign send_ok   = send_edge && !rx_mode && !tx_busy && !bus.empty
                       && !send_pend && !rd_busy && !tx_start;

    //////////////////////////////
    // Bus sequencing

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            load_q    <= 1'b0;
            send_q    <= 1'b0;
            rx_pend   <= 1'b0;
            ld_pend   <= 1'b0;
            send_pend <= 1'b0;
            bus.cyc   <= 1'b0;
            bus.stb   <= 1'b0;
            bus.we    <= 1'b0;
            tx_start  <= 1'b0;
        end
        else
        begin
            load_q   <= load;
            send_q   <= send;
            tx_start <= 1'b0;
            if (bus.cyc)
            begin
                if (bus.ack)
                begin
                    bus.cyc  <= 1'b0;           // Idle cycle follows
                    bus.stb  <= 1'b0;
                    tx_start <= !bus.we;        // Read data goes to the line
                end
            end
            else if (rx_pend)                   // Received byte wins over load
            begin
                rx_pend <= 1'b0;
                bus.cyc <= !bus.full;           // Dropped when full
                bus.stb <= !bus.full;
                bus.we  <= 1'b1;
            end
            else if (ld_pend)
            begin
                ld_pend <= 1'b0;
                bus.cyc <= !bus.full;
                bus.stb <= !bus.full;
                bus.we  <= 1'b1;
            end
            else if (send_pend)
            begin
                send_pend <= 1'b0;
                bus.cyc   <= !bus.empty;
                bus.stb   <= !bus.empty;
                bus.we    <= 1'b0;
            end
            // New requests overwrite, so they come last
            if (rx_valid && rx_mode)
                rx_pend <= 1'b1;
            if (load_edge && rx_mode)
                ld_pend <= 1'b1;
            if (send_ok)
                send_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rx_valid && rx_mode)
            rx_byte <= rx_data;
        if (load_edge && rx_mode)
            ld_byte <= load_data;
        if (!bus.cyc)
            bus.dat_w <= rx_pend ? rx_byte : ld_byte; // Same priority as above
        if (bus.cyc && bus.ack && !bus.we)
            tx_data <= bus.dat_r;
    end

endmodule

// File: tb_uart_fifo.sv
`include "uart_consts.svh"

module tb_uart_fifo
    import uart_pkg::*;
();

    localparam int BIT_CLKS  = 16;              // Cycles per serial bit
    localparam int IDLE_BITS = 20;              // Quiet window when no frame is expected
    localparam int WAIT_MAX  = 64;              // Cycles allowed for any response
    localparam int FRAME_W   = `UART_DATA_BITS + 2;

    logic        clk;
    logic        rst_n;
    logic        mode;
    logic        rx_serial;
    logic        load;
    byte_t       load_data;
    logic        send;
    logic        tx_serial;
    logic        fifo_empty;
    logic        fifo_full;
    byte_t       last_written;
    byte_t       next_out;

    logic [31:0] rand_state;                    // LCG state
    byte_t       model_q[$];                    // Reference FIFO contents, oldest first
    byte_t       model_last;                    // Reference last-written byte

    uart_fifo_top #(.CLKS_PER_BIT(BIT_CLKS)) dut_i (
        .clk(clk), .rst_n(rst_n), .mode(mode), .rx_serial(rx_serial),
        .load(load), .load_data(load_data), .send(send), .tx_serial(tx_serial),
        .fifo_empty(fifo_empty), .fifo_full(fifo_full),
        .last_written(last_written), .next_out(next_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;                  // Period 8
    end

    //////////////////////////////
    // Model and checking

    function automatic byte_t next_byte();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state[23:16];               // Upper bits are the better ones
    endfunction

    function automatic byte_t model_head();
        if (model_q.size() == 0)
            return '0;                          // Empty store shows 0
        return model_q[0];
    endfunction

    function automatic logic outputs_match();
        return last_written === model_last && next_out === model_head()
            && fifo_empty === (model_q.size() == 0)
            && fifo_full === (model_q.size() == `FIFO_DEPTH);
    endfunction

    // Writes only in receive mode and only into free space
    task automatic store_in_model(input byte_t data);
        if (mode == 1'b0 && model_q.size() < `FIFO_DEPTH)
        begin
            model_q.push_back(data);
            model_last = data;
        end
    endtask

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
            stop_with_failure($sformatf("Mismatch %s expected 0x%0h actual 0x%0h",
                                        name, expected, actual));
    endtask

    task automatic check_state(input string name);
        int waited;
        waited = 0;
        @(negedge clk);                         // Outputs are stable mid-cycle
        while (!outputs_match() && waited < WAIT_MAX)
        begin
            @(negedge clk);
            waited++;
        end
        check({name, " last_written"}, model_last, last_written);
        check({name, " next_out"}, model_head(), next_out);
        check({name, " fifo_empty"}, model_q.size() == 0, fifo_empty);
        check({name, " fifo_full"}, model_q.size() == `FIFO_DEPTH, fifo_full);
    endtask

    //////////////////////////////
    // Serial side

    task automatic send_frame(input byte_t data, input logic bad_stop);
        logic [FRAME_W-1:0] bits;
        bits = {~bad_stop, data, 1'b0};         // Stop, data LSB first, start
        @(posedge clk);
        for (int i = 0; i < FRAME_W; i++)
        begin
            rx_serial <= bits[i];
            repeat (BIT_CLKS) @(posedge clk);
        end
        rx_serial <= 1'b1;
        repeat (BIT_CLKS) @(posedge clk);       // One idle bit between frames
    endtask

    task automatic decode_frame(input string name, output byte_t data);
        int waited;
        waited = 0;
        @(negedge clk);
        while (tx_serial !== 1'b0)              // Hunt for the start bit
        begin
            if (waited == WAIT_MAX)
                stop_with_failure({"Timeout, no start bit on tx_serial for ", name});
            @(negedge clk);
            waited++;
        end
        repeat (BIT_CLKS / 2) @(negedge clk);   // Middle of start bit
        check({name, " start bit"}, 1'b0, tx_serial);
        for (int i = 0; i < `UART_DATA_BITS; i++)
        begin
            repeat (BIT_CLKS) @(negedge clk);
            data[i] = tx_serial;
        end
        repeat (BIT_CLKS) @(negedge clk);
        check({name, " stop bit"}, 1'b1, tx_serial);
        repeat (BIT_CLKS) @(negedge clk);       // Let the frame and busy flag end
    endtask

    //////////////////////////////
    // Stimulus

    task automatic receive_byte(input string name);
        byte_t data;
        data = next_byte();
        send_frame(data, 1'b0);
        store_in_model(data);
        check_state(name);
    endtask

    task automatic load_byte(input string name);
        byte_t data;
        data = next_byte();
        @(posedge clk);
        load_data <= data;
        load      <= 1'b1;
        repeat (2) @(posedge clk);
        load      <= 1'b0;
        repeat (4) @(posedge clk);              // Store lands within 4 cycles of the edge
        store_in_model(data);
        check_state(name);
    endtask

    task automatic pulse_send();
        @(posedge clk);
        send <= 1'b1;
        repeat (2) @(posedge clk);
        send <= 1'b0;
    endtask

    task automatic transmit_one(input string name);
        byte_t got;
        byte_t expected;
        pulse_send();
        decode_frame(name, got);
        expected = model_q.pop_front();         // Oldest byte leaves first
        check({name, " data"}, expected, got);
        check_state(name);
    endtask

    task automatic expect_no_frame(input string name);
        pulse_send();
        repeat (IDLE_BITS * BIT_CLKS)
        begin
            @(negedge clk);
            if (tx_serial !== 1'b1)
                stop_with_failure({"Unexpected frame on tx_serial after ", name});
        end
        check_state(name);
    endtask

    initial
    begin
        byte_t kind;
        rand_state = 32'd45377;
        model_last = '0;
        rst_n      = 1'b0;
        mode       = 1'b0;                      // Receive mode
        rx_serial  = 1'b1;
        load       = 1'b0;
        load_data  = '0;
        send       = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        check_state("after reset");
        check("after reset tx_serial", 1'b1, tx_serial);

        receive_byte("rx 0");
        send_frame(next_byte(), 1'b1);          // Low stop bit
        check_state("bad stop bit");
        for (int i = 1; i < `FIFO_DEPTH; i++)
        begin
            kind = next_byte();
            if (kind[0])
                receive_byte($sformatf("mixed %0d rx", i));
            else
                load_byte($sformatf("mixed %0d load", i));
        end

        receive_byte("fifth rx dropped");       // Store is full here
        load_byte("fifth load dropped");
        expect_no_frame("send in receive mode");

        @(posedge clk);
        mode <= 1'b1;                           // Transmit mode
        transmit_one("tx 0");
        receive_byte("rx in transmit mode");
        load_byte("load in transmit mode");
        for (int i = 1; i < `FIFO_DEPTH; i++)
            transmit_one($sformatf("tx %0d", i));
        check_state("drained");
        expect_no_frame("send when empty");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

//////////////////////////////
// Serial framing

// Data bits per 8N1 frame
`define UART_DATA_BITS 8

// 115200 baud from a 100 MHz clock
`define UART_CLKS_PER_BIT 868

//////////////////////////////
// Storage

`define FIFO_DEPTH 4                  // Entries in the byte store

`endif

// File: uart_fifo_top.sv
`include "uart_consts.svh"

module uart_fifo_top
    import uart_pkg::*, fifo_bus_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mode,                         // 0 receive, 1 transmit
    input  logic  rx_serial,
    input  logic  load,
    input  byte_t load_data,
    input  logic  send,
    output logic  tx_serial,
    output logic  fifo_empty,
    output logic  fifo_full,
    output byte_t last_written,
    output byte_t next_out
);

    byte_t rx_data;
    logic  rx_valid;
    byte_t tx_data;
    logic  tx_start;
    logic  tx_busy;

    fifo_bus_if bus_i ();

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx_i (
        .clk(clk), .rst_n(rst_n), .rx_serial(rx_serial),
        .rx_data(rx_data), .rx_valid(rx_valid)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx_i (
        .clk(clk), .rst_n(rst_n), .tx_start(tx_start), .tx_data(tx_data),
        .tx_serial(tx_serial), .tx_busy(tx_busy)
    );

    link_ctrl ctrl_i (
        .bus(bus_i), .clk(clk), .rst_n(rst_n), .mode(link_mode_t'(mode)),
        .rx_data(rx_data), .rx_valid(rx_valid), .load(load), .load_data(load_data),
        .send(send), .tx_busy(tx_busy), .tx_start(tx_start), .tx_data(tx_data)
    );

    byte_fifo fifo_i (.bus(bus_i), .clk(clk), .rst_n(rst_n));

    assign fifo_empty   = bus_i.empty;          // Status straight from the store
    assign fifo_full    = bus_i.full;
    assign last_written = bus_i.last;
    assign next_out     = bus_i.head;

endmodule

// File: uart_pkg.sv
`include "uart_consts.svh"

package uart_pkg;

    typedef logic [`UART_DATA_BITS-1:0] byte_t; // One data byte

    // Receiver phases, one per part of the frame
    typedef enum logic [1:0] {
        RX_IDLE,                                // Waiting for line low
        RX_START,                               // Checking start bit at mid-bit
        RX_DATA,                                // Sampling data bits
        RX_STOP                                 // Checking stop bit
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,                                // Line held high
        TX_START,                               // Driving start bit
        TX_DATA,                                // Shifting data, LSB first
        TX_STOP                                 // Driving stop bit
    } tx_state_t;

endpackage

// File: uart_rx.sv
`include "uart_consts.svh"

module uart_rx
    import uart_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rx_serial,
    output byte_t rx_data,
    output logic  rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(`UART_DATA_BITS);
    localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(`UART_DATA_BITS - 1);

    logic             rx_meta;                  // First sync stage
    logic             rx_s;                     // Synchronized line
    rx_state_t        state;
    logic [CNT_W-1:0] cnt;                      // Cycles within current bit
    logic [IDX_W-1:0] bit_idx;
    byte_t            shift_q;                  // Assembles the byte LSB first

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rx_meta <= 1'b1;                    // Idle line is high
            rx_s    <= 1'b1;
        end
        else
        begin
            rx_meta <= rx_serial;
            rx_s    <= rx_meta;
        end
    end

    //////////////////////////////
    // Frame FSM

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;                   // Pulse by default
            case (state)
                RX_IDLE:
                begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!rx_s)
                        state <= RX_START;      // Falling edge seen
                end
                RX_START:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == HALF_END)
                    begin
                        cnt   <= '0;
                        state <= rx_s ? RX_IDLE : RX_DATA; // Glitch, not a start bit
                    end
                end
                RX_DATA:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == BIT_END)
                    begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT)
                            state <= RX_STOP;
                    end
                end
                RX_STOP:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == BIT_END)
                    begin
                        cnt      <= '0;
                        state    <= RX_IDLE;
                        rx_valid <= rx_s;       // Low stop bit drops the frame
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data path
    always_ff @(posedge clk)
    begin
        if (state == RX_DATA && cnt == BIT_END)
            shift_q <= {rx_s, shift_q[`UART_DATA_BITS-1:1]};
        if (state == RX_STOP && cnt == BIT_END && rx_s)
            rx_data <= shift_q;                 // Present together with rx_valid
    end

    a_rx_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid);

endmodule

// File: uart_tx.sv
`include "uart_consts.svh"

module uart_tx
    import uart_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  tx_start,
    input  byte_t tx_data,
    output logic  tx_serial,
    output logic  tx_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(`UART_DATA_BITS);
    localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(`UART_DATA_BITS - 1);

    tx_state_t        state;
    logic [CNT_W-1:0] cnt;                      // Cycles within current bit
    logic [IDX_W-1:0] bit_idx;
    byte_t            shift_q;                  // Next bit always at [0]
    logic             bit_done;

    assign bit_done = (cnt == BIT_END);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= TX_IDLE;
            cnt       <= '0;
            bit_idx   <= '0;
            tx_serial <= 1'b1;
            tx_busy   <= 1'b0;
        end
        else
        begin
            cnt <= bit_done ? '0 : cnt + 1'b1;
            case (state)
                TX_IDLE:
                begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (tx_start)
                    begin
                        state     <= TX_START;
                        tx_serial <= 1'b0;      // Start bit next cycle
                        tx_busy   <= 1'b1;
                    end
                end
                TX_START:
                    if (bit_done)
                    begin
                        state     <= TX_DATA;
                        tx_serial <= shift_q[0];
                    end
                TX_DATA:
                    if (bit_done)
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT)
                        begin
                            state     <= TX_STOP;
                            tx_serial <= 1'b1;
                        end
                        else
                            tx_serial <= shift_q[0];
                    end
                TX_STOP:
                    if (bit_done)
                    begin
                        state   <= TX_IDLE;
                        tx_busy <= 1'b0;        // Frame complete
                    end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Byte latch and shifter
    always_ff @(posedge clk)
    begin
        if (state == TX_IDLE && tx_start)
            shift_q <= tx_data;
        else if ((state == TX_START || state == TX_DATA) && bit_done)
            shift_q <= shift_q >> 1;
    end

    // Controller must wait for the frame to finish
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> !tx_busy);

endmodule
